/* compile.f */
+incdir+source
source/bus_pkg.sv
source/pipe_reg.sv
source/bus_decode.sv
source/word_ram.sv
source/platform_io.sv
source/platform.sv
source/conspiracion.sv
dv/tb_conspiracion.sv

/* dv/tb_conspiracion.sv */
`include "conspiracion_defines.svh"

module tb_conspiracion;

	timeunit 1ns;
	timeprecision 1ps;

	// the tests run for about 150 cycles.
	localparam int max_cycles = 4000;

	logic        clk_clk = 1'b0;
	logic        rst_n = 1'b0;
	logic [29:0] addr = '0;
	logic [31:0] data_wr = '0;
	logic        write = 1'b0;
	logic        start = 1'b0;
	logic [31:0] data_rd;
	logic        ready;
	logic        irq;
	logic [7:0]  pio_leds;

	integer      seed = 32'he3c3;
	int unsigned cyc = 0;
	int unsigned last_ready_cyc = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	// one entry per request still waiting for its ready.
	logic [31:0] exp_data[$];
	logic        exp_check[$];
	int unsigned exp_due[$];

	logic [31:0] ram_model [`RAM_WORDS];
	int unsigned used_off [8];

	conspiracion dut0
	(
		.clk_clk(clk_clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_wr(data_wr),
		.write(write),
		.start(start),
		.data_rd(data_rd),
		.ready(ready),
		.irq(irq),
		.pio_leds(pio_leds)
	);

	always #50 clk_clk = ~clk_clk;

	always @(posedge clk_clk) begin
		cyc <= cyc + 1;
	end

	task automatic value_error(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors == errs_at_start) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_at_start);
		end
	endtask

	function automatic logic [29:0] ram_addr(input int unsigned off);
		return {`RAM_REGION, 28'(off)};
	endfunction

	function automatic logic [29:0] io_addr(input int unsigned off);
		return {`IO_REGION, 28'(off)};
	endfunction

	// one start pulse; back to back calls give back to back starts.
	task automatic issue(input logic [29:0] a, input logic [31:0] d, input logic w,
			input logic chk, input logic [31:0] want);
		@(posedge clk_clk);
		addr    <= a;
		data_wr <= d;
		write   <= w;
		start   <= 1'b1;
		exp_data.push_back(want);
		exp_check.push_back(chk);
	endtask

	task automatic drain();
		@(posedge clk_clk);
		start <= 1'b0;
		write <= 1'b0;
		while (exp_data.size() != 0)
			@(negedge clk_clk);
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk_clk) begin : monitor
		int unsigned due;
		logic [31:0] want;
		logic        chk;

		if (!rst_n) begin
			if (cyc >= 1) begin
				assert (ready === 1'b0 && irq === 1'b0 && pio_leds === 8'd0)
				else value_error("outputs not zero during reset");
			end
		end else begin
			if (start)
				exp_due.push_back(cyc + 3); // ready three cycles after the start cycle.
			if (ready) begin
				if (exp_due.size() == 0) begin
					$display("ERROR at %0t ns: ready pulse with no request outstanding", $time);
					errors++;
				end else begin
					due  = exp_due.pop_front();
					want = exp_data.pop_front();
					chk  = exp_check.pop_front();
					last_ready_cyc = cyc;
					assert (due == cyc)
					else value_error($sformatf("ready at cycle %0d, expected at %0d", cyc, due));
					if (chk) begin
						assert (data_rd === want)
						else value_error($sformatf("data_rd %h, expected %h", data_rd, want));
					end
				end
			end else if (exp_due.size() != 0 && exp_due[0] < cyc) begin
				$display("ERROR at %0t ns: no ready pulse for the request due at cycle %0d",
					$time, exp_due[0]);
				errors++;
				void'(exp_due.pop_front());
				void'(exp_data.pop_front());
				void'(exp_check.pop_front());
			end
		end
	end

	always @(negedge clk_clk) begin
		if (cyc >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_reset();
		int errs;
		errs = errors;
		repeat (10) @(posedge clk_clk);
		rst_n <= 1'b1;
		repeat (5) begin
			@(negedge clk_clk);
			assert (ready === 1'b0 && irq === 1'b0 && pio_leds === 8'd0)
			else value_error("outputs not zero right after reset");
		end
		finish_test("reset", errs);
	endtask

	task automatic ram_write_read();
		int          errs;
		logic [31:0] d;
		errs = errors;
		// the low three bits hold the index so the offsets are distinct.
		for (int i = 0; i < 8; i++)
			used_off[i] = ($unsigned($random(seed)) % 128) * 8 + i;
		for (int i = 0; i < 8; i++) begin
			d = $random(seed);
			ram_model[used_off[i]] = d;
			issue(ram_addr(used_off[i]), d, 1'b1, 1'b0, 32'd0);
		end
		drain();
		for (int i = 0; i < 8; i++)
			issue(ram_addr(used_off[i]), 32'd0, 1'b0, 1'b1, ram_model[used_off[i]]);
		drain();
		finish_test("ram write then read", errs);
	endtask

	task automatic back_to_back();
		int          errs;
		int unsigned k;
		logic [31:0] r;
		logic [31:0] d;
		errs = errors;
		for (int i = 0; i < 16; i++) begin
			k = $unsigned($random(seed)) % 8;
			r = $random(seed);
			if (r[0]) begin
				d = $random(seed);
				ram_model[used_off[k]] = d;
				issue(ram_addr(used_off[k]), d, 1'b1, 1'b0, 32'd0);
			end else begin
				issue(ram_addr(used_off[k]), 32'd0, 1'b0, 1'b1, ram_model[used_off[k]]);
			end
		end
		drain();
		finish_test("back to back", errs);
	endtask

	task automatic led_register();
		int          errs;
		logic [31:0] lv;
		errs = errors;
		repeat (2) begin
			lv = $random(seed);
			issue(io_addr(`IO_LEDS), lv, 1'b1, 1'b0, 32'd0);
			drain();
			assert (pio_leds === lv[7:0])
			else value_error($sformatf("pio_leds %h, expected %h", pio_leds, lv[7:0]));
			issue(io_addr(`IO_LEDS), 32'd0, 1'b0, 1'b1, {24'd0, lv[7:0]});
			drain();
		end
		finish_test("led register", errs);
	endtask

	task automatic unmapped_reads();
		int errs;
		errs = errors;
		issue(ram_addr(`RAM_WORDS), 32'd0, 1'b0, 1'b1, 32'd0); // just past the ram.
		issue(ram_addr(32'h0ff_ffff), 32'd0, 1'b0, 1'b1, 32'd0);
		issue(io_addr(`IO_IRQ_STATUS + 1), 32'd0, 1'b0, 1'b1, 32'd0);
		issue(io_addr(32'h000_0100), 32'd0, 1'b0, 1'b1, 32'd0);
		issue({2'b01, 28'd0}, 32'd0, 1'b0, 1'b1, 32'd0);
		issue({2'b10, 28'h123}, 32'd0, 1'b0, 1'b1, 32'd0);
		drain();
		finish_test("unmapped reads", errs);
	endtask

	task automatic timer_irq();
		int          errs;
		int unsigned n;
		int unsigned s;
		int unsigned rise;
		errs = errors;
		n = 20 + $unsigned($random(seed)) % 16;
		assert (irq === 1'b0) else value_error("irq high before the compare is set");
		issue(io_addr(`IO_TIMER_CMP), n, 1'b1, 1'b0, 32'd0);
		@(negedge clk_clk);
		s = cyc; // the cycle that carries the start pulse.
		drain();
		while (irq !== 1'b1 && cyc < s + n + 8)
			@(negedge clk_clk);
		rise = cyc;
		assert (irq === 1'b1 && rise >= s + n && rise <= s + n + 4)
		else value_error($sformatf("irq at cycle %0d, window %0d to %0d",
			rise, s + n, s + n + 4));
		issue(io_addr(`IO_IRQ_STATUS), 32'd0, 1'b0, 1'b1, 32'd1);
		issue(io_addr(`IO_TIMER_CMP), 32'd0, 1'b0, 1'b1, n);
		drain();
		issue(io_addr(`IO_IRQ_STATUS), 32'd1, 1'b1, 1'b0, 32'd0);
		drain();
		while (irq === 1'b1 && cyc < last_ready_cyc + 4)
			@(negedge clk_clk);
		assert (irq === 1'b0) else value_error("irq still high four cycles after the clear");
		issue(io_addr(`IO_IRQ_STATUS), 32'd0, 1'b0, 1'b1, 32'd0);
		drain();
		finish_test("timer irq", errs);
	endtask

	initial begin
		check_reset();
		ram_write_read();
		back_to_back();
		led_register();
		unmapped_reads();
		timer_irq();
		repeat (4) @(negedge clk_clk);
		$display("tests: %0d run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_passed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the conspiracion testbench with verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -j 0 --top-module tb_conspiracion \
	-f compile.f -o sim_conspiracion \
	&& ./obj_dir/sim_conspiracion > "$log" 2>&1 \
	|| { cat "$log" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$log"
grep -qF '*** TEST FAILED ***' "$log" && { echo "failure reported in $log"; exit 1; }
grep -qF '*** TEST PASSED ***' "$log" || { echo "no result line in $log"; exit 1; }
exit 0

/* source/bus_decode.sv */
`include "conspiracion_defines.svh"

module bus_decode
(
	input  bus_pkg::bus_req_t req,
	input  logic              req_valid,
	output bus_pkg::decoded_t dec,
	output logic              ram_en,
	output logic              io_en
);

	import bus_pkg::*;

	localparam int io_regs = `IO_IRQ_STATUS + 1;

	logic [1:0]  region;
	logic [27:0] word;
	logic        ram_hit;
	logic        io_hit;

	assign region = req.addr[29:28];
	assign word   = req.addr[27:0];

	// anything past the end of a region falls through to tgt_none.
	assign ram_hit = (region == `RAM_REGION) && (word < 28'(`RAM_WORDS));
	assign io_hit  = (region == `IO_REGION) && (word < 28'(io_regs));

	always_comb begin
		dec.req    = req;
		dec.offset = word[11:0];

		if (ram_hit)
			dec.target = tgt_ram;
		else if (io_hit)
			dec.target = tgt_io;
		else
			dec.target = tgt_none;
	end

	assign ram_en = req_valid && (dec.target == tgt_ram);
	assign io_en  = req_valid && (dec.target == tgt_io);

endmodule

/* source/bus_pkg.sv */
package bus_pkg;

	// one core bus request as it enters the pipeline.
	typedef struct packed {
		logic [29:0] addr;    // word address.
		logic [31:0] data_wr;
		logic        write;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] data_rd;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		tgt_ram  = 2'd0,
		tgt_io   = 2'd1,
		tgt_none = 2'd2
	} target_t;

	// request after the address map lookup.
	typedef struct packed {
		bus_req_t    req;
		target_t     target;
		logic [11:0] offset; // word offset inside the target.
	} decoded_t;

endpackage

/* source/conspiracion.sv */
module conspiracion
(
	input  wire        clk_clk,
	input  wire        rst_n,
	input  wire [29:0] addr,
	input  wire [31:0] data_wr,
	input  wire        write,
	input  wire        start,
	output wire [31:0] data_rd,
	output wire        ready,
	output wire        irq,
	output wire [7:0]  pio_leds
);

	// the core sits outside and drives the bus ports.
	platform plat
	(
		.clk_clk(clk_clk),
		.rst_n(rst_n),
		.addr(addr),
		.data_wr(data_wr),
		.write(write),
		.start(start),
		.data_rd(data_rd),
		.ready(ready),
		.irq(irq),
		.pio_leds(pio_leds)
	);

endmodule

/* source/conspiracion_defines.svh */
`ifndef CONSPIRACION_DEFINES_SVH
`define CONSPIRACION_DEFINES_SVH

// word ram.
`define RAM_WORDS 1024

// top two bits of the word address pick the region.
`define RAM_REGION 2'b00
`define IO_REGION  2'b11

// i/o register word offsets.
`define IO_LEDS        0
`define IO_TIMER_COUNT 1
`define IO_TIMER_CMP   2
`define IO_IRQ_STATUS  3

`endif

/* source/pipe_reg.sv */
module pipe_reg
#(
	parameter type payload_t = logic
)
(
	input  logic     clk_clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	always_ff @(posedge clk_clk) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= in_valid;
	end

	always_ff @(posedge clk_clk) begin
		if (in_valid)
			data_q <= in_data; // holds the last payload when idle.
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

endmodule

/* source/platform.sv */
`include "conspiracion_defines.svh"

module platform
(
	input  logic        clk_clk,
	input  logic        rst_n,
	input  logic [29:0] addr,
	input  logic [31:0] data_wr,
	input  logic        write,
	input  logic        start,
	output logic [31:0] data_rd,
	output logic        ready,
	output logic        irq,
	output logic [7:0]  pio_leds
);

	import bus_pkg::*;

	localparam int ram_aw = $clog2(`RAM_WORDS);

	// what an access in stage 2 needs to pick its response.
	typedef struct packed {
		target_t target;
		logic    write;
	} acc_t;

	bus_req_t req_in;
	bus_req_t req_q;
	logic     req_valid;
	decoded_t dec;
	logic     ram_en;
	logic     io_en;
	bus_rsp_t ram_rd;
	bus_rsp_t io_rd;
	acc_t     acc_in;
	acc_t     acc_q;
	logic     acc_valid;
	bus_rsp_t rsp_in;
	bus_rsp_t rsp_q;

	assign req_in = '{addr: addr, data_wr: data_wr, write: write};

	pipe_reg #(.payload_t(bus_req_t)) req_stage
	(
		.clk_clk(clk_clk),
		.rst_n(rst_n),
		.in_valid(start),
		.in_data(req_in),
		.out_valid(req_valid),
		.out_data(req_q)
	);

	bus_decode decode
	(
		.req(req_q),
		.req_valid(req_valid),
		.dec(dec),
		.ram_en(ram_en),
		.io_en(io_en)
	);

	word_ram ram
	(
		.clk_clk(clk_clk),
		.en(ram_en),
		.we(dec.req.write),
		.offset(dec.offset[ram_aw-1:0]),
		.data_wr(dec.req.data_wr),
		.data_rd(ram_rd)
	);

	platform_io io
	(
		.clk_clk(clk_clk),
		.rst_n(rst_n),
		.en(io_en),
		.we(dec.req.write),
		.offset(dec.offset[1:0]),
		.data_wr(dec.req.data_wr),
		.data_rd(io_rd),
		.pio_leds(pio_leds),
		.irq(irq)
	);

	assign acc_in = '{target: dec.target, write: dec.req.write};

	// lines up with the targets' registered read data.
	pipe_reg #(.payload_t(acc_t)) acc_stage
	(
		.clk_clk(clk_clk),
		.rst_n(rst_n),
		.in_valid(req_valid),
		.in_data(acc_in),
		.out_valid(acc_valid),
		.out_data(acc_q)
	);

	always_comb begin
		rsp_in = '0; // writes and unmapped reads answer zero.
		if (!acc_q.write) begin
			case (acc_q.target)
				tgt_ram: rsp_in = ram_rd;
				tgt_io:  rsp_in = io_rd;
				default: rsp_in = '0;
			endcase
		end
	end

	pipe_reg #(.payload_t(bus_rsp_t)) rsp_stage
	(
		.clk_clk(clk_clk),
		.rst_n(rst_n),
		.in_valid(acc_valid),
		.in_data(rsp_in),
		.out_valid(ready),
		.out_data(rsp_q)
	);

	assign data_rd = rsp_q.data_rd;

endmodule

/* source/platform_io.sv */
`include "conspiracion_defines.svh"

module platform_io
(
	input  logic              clk_clk,
	input  logic              rst_n,
	input  logic              en,
	input  logic              we,
	input  logic [1:0]        offset,
	input  logic [31:0]       data_wr,
	output bus_pkg::bus_rsp_t data_rd,
	output logic [7:0]        pio_leds,
	output logic              irq
);

	logic [7:0]  leds_q;
	logic [31:0] count_q;
	logic [31:0] cmp_q;
	logic        irq_q;
	logic [31:0] rd_q;
	logic        wr;
	logic        cmp_hit;

	assign wr      = en && we;
	assign cmp_hit = (cmp_q != 32'd0) && (count_q == cmp_q); // zero disarms the timer.

	always_ff @(posedge clk_clk) begin
		if (!rst_n) begin
			leds_q  <= 8'd0;
			count_q <= 32'd0;
			cmp_q   <= 32'd0;
			irq_q   <= 1'b0;
		end else begin
			count_q <= count_q + 32'd1;

			if (wr && offset == 2'(`IO_LEDS))
				leds_q <= data_wr[7:0];

			if (wr && offset == 2'(`IO_TIMER_CMP)) begin
				cmp_q   <= data_wr;
				count_q <= 32'd0; // restart the count.
			end

			// write one to clear.
			if (wr && offset == 2'(`IO_IRQ_STATUS) && data_wr[0])
				irq_q <= 1'b0;

			if (cmp_hit)
				irq_q <= 1'b1;
		end
	end

	// the count register is read only.
	always_ff @(posedge clk_clk) begin
		if (en && !we) begin
			case (offset)
				2'(`IO_LEDS):        rd_q <= {24'd0, leds_q};
				2'(`IO_TIMER_COUNT): rd_q <= count_q;
				2'(`IO_TIMER_CMP):   rd_q <= cmp_q;
				2'(`IO_IRQ_STATUS):  rd_q <= {31'd0, irq_q};
				default:             rd_q <= 32'd0;
			endcase
		end
	end

	assign data_rd  = '{data_rd: rd_q};
	assign pio_leds = leds_q;
	assign irq      = irq_q;

endmodule

/* source/word_ram.sv */
`include "conspiracion_defines.svh"

module word_ram
(
	input  logic                             clk_clk,
	input  logic                             en,
	input  logic                             we,
	input  logic [$clog2(`RAM_WORDS)-1:0]    offset,
	input  logic [31:0]                      data_wr,
	output bus_pkg::bus_rsp_t                data_rd
);

	logic [31:0] mem [`RAM_WORDS];
	logic [31:0] rd_q;

	always_ff @(posedge clk_clk) begin
		if (en) begin
			if (we)
				mem[offset] <= data_wr;
			else
				rd_q <= mem[offset]; // read data one cycle after select.
		end
	end

	assign data_rd = '{data_rd: rd_q};

endmodule
